/* all.f */
+incdir+.
bus_pkg.sv
mem_req_if.sv
clint_rd_if.sv
bus_arbiter.sv
axi_master_port.sv
clint.sv
cpu_bus_top.sv
cpu_bus_tb.sv

/* axi_master_port.sv */
`timescale 1ns/100ps
`include "bus_macros.svh"

module axi_master_port (
  input  logic            clk,
  input  logic            rst,
  mem_req_if.port         mem,
  output bus_pkg::addr_t  m_araddr_o,
  output bus_pkg::size_t  m_arsize_o,
  output logic            m_arvalid_o,
  input  logic            m_arready_i,
  input  bus_pkg::beat_t  m_rdata_i,
  input  bus_pkg::resp_t  m_rresp_i,
  input  logic            m_rvalid_i,
  output logic            m_rready_o,
  output bus_pkg::addr_t  m_awaddr_o,
  output bus_pkg::size_t  m_awsize_o,
  output logic            m_awvalid_o,
  input  logic            m_awready_i,
  output bus_pkg::beat_t  m_wdata_o,
  output bus_pkg::strb_t  m_wstrb_o,
  output logic            m_wvalid_o,
  input  logic            m_wready_i,
  input  bus_pkg::resp_t  m_bresp_i,
  input  logic            m_bvalid_i,
  output logic            m_bready_o
);

  logic           active;
  logic           resp_wait;
  bus_pkg::word_t r_half;
  bus_pkg::word_t r_word;
  bus_pkg::word_t w_word;
  logic [3:0]     w_lane_strb;

  function automatic bus_pkg::size_t size_of(input bus_pkg::strb_t strb);
    case (strb)
      8'h01:   return 3'd0;
      8'h03:   return 3'd1;
      default: return 3'd2;
    endcase
  endfunction

  assign m_araddr_o = mem.addr;
  assign m_awaddr_o = mem.addr;
  assign m_arsize_o = size_of(mem.strb);
  assign m_awsize_o = size_of(mem.strb);
  assign m_rready_o = 1'b1;
  assign m_bready_o = 1'b1;

  // store word goes to both halves, strobe picks the half
  assign w_word      = mem.wdata << {mem.addr[1:0], 3'b000};
  assign m_wdata_o   = {w_word, w_word};
  assign w_lane_strb = mem.strb[3:0] << mem.addr[1:0];
  assign m_wstrb_o   = mem.addr[2] ? {w_lane_strb, 4'b0000} : {4'b0000, w_lane_strb};

  // pick the half, then drop the low bytes
  assign r_half = mem.addr[2] ? m_rdata_i[63:32] : m_rdata_i[31:0];
  assign r_word = r_half >> {mem.addr[1:0], 3'b000};

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      active      <= 1'b0;
      resp_wait   <= 1'b0;
      m_arvalid_o <= 1'b0;
      m_awvalid_o <= 1'b0;
      m_wvalid_o  <= 1'b0;
      mem.done    <= 1'b0;
    end
    else
    begin
      mem.done <= 1'b0;
      if (!active)
      begin
        // launch once per request
        if (mem.rd_valid)
        begin
          active      <= 1'b1;
          resp_wait   <= 1'b1;
          m_arvalid_o <= 1'b1;
        end
        else if (mem.wr_valid)
        begin
          active      <= 1'b1;
          resp_wait   <= 1'b1;
          m_awvalid_o <= 1'b1;
          m_wvalid_o  <= 1'b1;
        end
      end
      else
      begin
        if (m_arvalid_o && m_arready_i)
          m_arvalid_o <= 1'b0;
        if (m_awvalid_o && m_awready_i)
          m_awvalid_o <= 1'b0;
        if (m_wvalid_o && m_wready_i)
          m_wvalid_o <= 1'b0;
        if (resp_wait && mem.rd_valid && m_rvalid_i)
        begin
          resp_wait <= 1'b0;
          mem.done  <= 1'b1;
        end
        if (resp_wait && mem.wr_valid && m_bvalid_i)
        begin
          resp_wait <= 1'b0;
          mem.done  <= 1'b1;
        end
        // arbiter drops its request on done
        if (mem.done)
          active <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (active && resp_wait && mem.rd_valid && m_rvalid_i)
      mem.rdata <= r_word;
  end

  a_rresp_okay: assert property (@(posedge clk) disable iff (rst)
    m_rvalid_i |-> m_rresp_i == `BUS_RESP_OKAY);

  a_bresp_okay: assert property (@(posedge clk) disable iff (rst)
    m_bvalid_i |-> m_bresp_i == `BUS_RESP_OKAY);

  // address also holds, since the arbiter keeps it until done
  a_ar_hold: assert property (@(posedge clk) disable iff (rst)
    m_arvalid_o && !m_arready_i |=> m_arvalid_o && $stable(m_araddr_o));

endmodule

/* bus_arbiter.sv */
`timescale 1ns/100ps
`include "bus_macros.svh"

module bus_arbiter (
  input  logic            clk,
  input  logic            rst,
  input  bus_pkg::addr_t  ifu_araddr_i,
  input  logic            ifu_arvalid_i,
  input  bus_pkg::addr_t  lsu_araddr_i,
  input  logic            lsu_arvalid_i,
  input  bus_pkg::strb_t  lsu_rstrb_i,
  input  bus_pkg::addr_t  lsu_awaddr_i,
  input  bus_pkg::word_t  lsu_wdata_i,
  input  bus_pkg::strb_t  lsu_wstrb_i,
  input  logic            lsu_wvalid_i,
  output bus_pkg::word_t  ifu_rdata_o,
  output bus_pkg::word_t  lsu_rdata_o,
  output logic            ifu_rvalid_o,
  output logic            lsu_rvalid_o,
  output logic            lsu_wready_o,
  mem_req_if.arb          mem,
  clint_rd_if.arb         clint
);

  bus_pkg::arb_state_t state;
  logic                ifu_owner;
  logic                is_rtc;
  logic                resp_busy;
  logic                grant;

  assign is_rtc = (lsu_araddr_i == `BUS_RTC_ADDR) || (lsu_araddr_i == `BUS_RTC_ADDR_UP);

  // requester still holds its request while its pulse is out
  assign resp_busy = ifu_rvalid_o || lsu_rvalid_o || lsu_wready_o;
  assign grant = (state == bus_pkg::st_idle) && !resp_busy;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state        <= bus_pkg::st_idle;
      ifu_owner    <= 1'b0;
      mem.rd_valid <= 1'b0;
      mem.wr_valid <= 1'b0;
      clint.valid  <= 1'b0;
      ifu_rvalid_o <= 1'b0;
      lsu_rvalid_o <= 1'b0;
      lsu_wready_o <= 1'b0;
    end
    else
    begin
      ifu_rvalid_o <= 1'b0;
      lsu_rvalid_o <= 1'b0;
      lsu_wready_o <= 1'b0;
      clint.valid  <= 1'b0;
      case (state)
        bus_pkg::st_idle:
        begin
          // lsu load, then lsu store, then fetch
          if (grant)
          begin
            if (lsu_arvalid_i && is_rtc)
            begin
              clint.valid <= 1'b1;
              state       <= bus_pkg::st_clint_read;
            end
            else if (lsu_arvalid_i)
            begin
              mem.rd_valid <= 1'b1;
              ifu_owner    <= 1'b0;
              state        <= bus_pkg::st_mem_read;
            end
            else if (lsu_wvalid_i)
            begin
              mem.wr_valid <= 1'b1;
              state        <= bus_pkg::st_mem_write;
            end
            else if (ifu_arvalid_i)
            begin
              mem.rd_valid <= 1'b1;
              ifu_owner    <= 1'b1;
              state        <= bus_pkg::st_mem_read;
            end
          end
        end
        bus_pkg::st_mem_read:
        begin
          if (mem.done)
          begin
            mem.rd_valid <= 1'b0;
            ifu_rvalid_o <= ifu_owner;
            lsu_rvalid_o <= !ifu_owner;
            state        <= bus_pkg::st_idle;
          end
        end
        bus_pkg::st_clint_read:
        begin
          if (clint.rvalid)
          begin
            lsu_rvalid_o <= 1'b1;
            state        <= bus_pkg::st_idle;
          end
        end
        default:
        begin
          if (mem.done)
          begin
            mem.wr_valid <= 1'b0;
            lsu_wready_o <= 1'b1;
            state        <= bus_pkg::st_idle;
          end
        end
      endcase
    end
  end

  // request payload and returned data
  always_ff @(posedge clk)
  begin
    if (grant)
    begin
      if (lsu_arvalid_i)
      begin
        mem.addr   <= lsu_araddr_i;
        mem.strb   <= lsu_rstrb_i;
        clint.addr <= lsu_araddr_i;
      end
      else if (lsu_wvalid_i)
      begin
        mem.addr  <= lsu_awaddr_i;
        mem.strb  <= lsu_wstrb_i;
        mem.wdata <= lsu_wdata_i;
      end
      else if (ifu_arvalid_i)
      begin
        // fetches are always full words
        mem.addr <= ifu_araddr_i;
        mem.strb <= bus_pkg::strb_t'(8'h0f);
      end
    end
    if (state == bus_pkg::st_mem_read && mem.done)
    begin
      if (ifu_owner)
        ifu_rdata_o <= mem.rdata;
      else
        lsu_rdata_o <= mem.rdata;
    end
    if (state == bus_pkg::st_clint_read && clint.rvalid)
      lsu_rdata_o <= clint.rdata;
  end

  a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
    !(mem.rd_valid && mem.wr_valid));

  // a pulse always closes a transaction that was in flight
  a_pulse_after_busy: assert property (@(posedge clk) disable iff (rst)
    resp_busy |-> $past(state) != bus_pkg::st_idle);

endmodule

/* bus_macros.svh */
`ifndef BUS_MACROS_SVH
`define BUS_MACROS_SVH

// bus widths
`define BUS_ADDR_W 32
`define BUS_DATA_W 32
`define BUS_BEAT_W 64

// machine timer, read as two words
`define BUS_RTC_ADDR    32'h0200_bff8
`define BUS_RTC_ADDR_UP 32'h0200_bffc

// axi response codes
`define BUS_RESP_OKAY 2'b00

`endif

/* bus_pkg.sv */
`include "bus_macros.svh"

package bus_pkg;

  // byte address and core data word
  typedef logic [`BUS_ADDR_W-1:0] addr_t;
  typedef logic [`BUS_DATA_W-1:0] word_t;

  // one axi data beat and its byte strobe
  typedef logic [`BUS_BEAT_W-1:0] beat_t;
  typedef logic [`BUS_BEAT_W/8-1:0] strb_t;

  // axsize encoding, log2 of bytes per beat
  typedef logic [2:0] size_t;

  // xresp field
  typedef logic [1:0] resp_t;

  // arbiter states
  typedef enum logic [1:0] {
    st_idle,
    st_mem_read,
    st_clint_read,
    st_mem_write
  } arb_state_t;

endpackage

/* clint.sv */
`timescale 1ns/100ps
`include "bus_macros.svh"

module clint (
  input  logic      clk,
  input  logic      rst,
  clint_rd_if.clint rd
);

  logic [2*`BUS_DATA_W-1:0] mtime;

  // free running machine timer
  always_ff @(posedge clk)
  begin
    if (rst)
      mtime <= '0;
    else
      mtime <= mtime + 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      rd.rvalid <= 1'b0;
    else
      rd.rvalid <= rd.valid;
  end

  // word select by address
  always_ff @(posedge clk)
  begin
    if (rd.valid)
    begin
      case (rd.addr)
        `BUS_RTC_ADDR:    rd.rdata <= mtime[`BUS_DATA_W-1:0];
        `BUS_RTC_ADDR_UP: rd.rdata <= mtime[2*`BUS_DATA_W-1:`BUS_DATA_W];
        default:          rd.rdata <= '0;
      endcase
    end
  end

  // only timer addresses are routed here
  a_rtc_addr: assert property (@(posedge clk) disable iff (rst)
    rd.valid |-> (rd.addr == `BUS_RTC_ADDR) || (rd.addr == `BUS_RTC_ADDR_UP));

  a_valid_single: assert property (@(posedge clk) disable iff (rst)
    rd.valid |=> !rd.valid);

endmodule

/* clint_rd_if.sv */
`timescale 1ns/100ps

interface clint_rd_if;

  // single cycle read request
  logic           valid;
  bus_pkg::addr_t addr;

  // data returns one cycle later
  logic           rvalid;
  bus_pkg::word_t rdata;

  modport arb (
    output valid,
    output addr,
    input  rvalid,
    input  rdata
  );

  modport clint (
    input  valid,
    input  addr,
    output rvalid,
    output rdata
  );

endinterface

/* cpu_bus_tb.sv */
`timescale 1ns/100ps
`include "bus_macros.svh"

module cpu_bus_tb;

  logic           clk = 1'b0;
  logic           rst;
  bus_pkg::addr_t ifu_araddr_i;
  logic           ifu_arvalid_i;
  bus_pkg::word_t ifu_rdata_o;
  logic           ifu_rvalid_o;
  bus_pkg::addr_t lsu_araddr_i;
  logic           lsu_arvalid_i;
  bus_pkg::strb_t lsu_rstrb_i;
  bus_pkg::word_t lsu_rdata_o;
  logic           lsu_rvalid_o;
  bus_pkg::addr_t lsu_awaddr_i;
  bus_pkg::word_t lsu_wdata_i;
  bus_pkg::strb_t lsu_wstrb_i;
  logic           lsu_wvalid_i;
  logic           lsu_wready_o;
  bus_pkg::addr_t m_araddr_o;
  bus_pkg::size_t m_arsize_o;
  logic           m_arvalid_o;
  logic           m_arready_i;
  bus_pkg::beat_t m_rdata_i;
  bus_pkg::resp_t m_rresp_i;
  logic           m_rvalid_i;
  logic           m_rready_o;
  bus_pkg::addr_t m_awaddr_o;
  bus_pkg::size_t m_awsize_o;
  logic           m_awvalid_o;
  logic           m_awready_i;
  bus_pkg::beat_t m_wdata_o;
  bus_pkg::strb_t m_wstrb_o;
  logic           m_wvalid_o;
  logic           m_wready_i;
  bus_pkg::resp_t m_bresp_i;
  logic           m_bvalid_i;
  logic           m_bready_o;

  // slave memory with one beat per 8-byte aligned key
  bus_pkg::beat_t ram [bus_pkg::addr_t];
  integer         seed = 32'h77ed35cb;
  int             err_count = 0;
  int             test_count = 0;
  int             ar_count = 0;
  int             aw_count = 0;
  bus_pkg::size_t last_arsize;
  bus_pkg::size_t last_awsize;
  bus_pkg::strb_t last_wstrb;

  // slave model state
  int             ar_wait;
  int             r_wait;
  int             aw_wait;
  int             w_wait;
  int             b_wait;
  bit             r_pend;
  bit             aw_got;
  bit             w_got;
  bit             b_pend;
  bus_pkg::addr_t r_addr;
  bus_pkg::addr_t w_addr;
  bus_pkg::beat_t w_data;
  bus_pkg::strb_t w_strb;
  bus_pkg::beat_t wb;

  cpu_bus_top cpu_bus_top_i (.*);

  always #20 clk = ~clk;

  function automatic int unsigned urand(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic bus_pkg::beat_t fill(input bus_pkg::addr_t key);
    return {key ^ 32'h3c5a_96e1, ~key};
  endfunction

  function automatic bus_pkg::beat_t mem_peek(input bus_pkg::addr_t a);
    bus_pkg::addr_t key;
    key = {a[31:3], 3'b000};
    if (ram.exists(key))
      return ram[key];
    return fill(key);
  endfunction

  // half by addr[2], then drop the low bytes
  function automatic bus_pkg::word_t exp_read(input bus_pkg::beat_t b, input bus_pkg::addr_t a);
    bus_pkg::word_t half;
    half = a[2] ? b[63:32] : b[31:0];
    return half >> (8 * a[1:0]);
  endfunction

  function automatic bus_pkg::size_t exp_size(input bus_pkg::strb_t s);
    if (s == 8'h01)
      return 3'd0;
    else if (s == 8'h03)
      return 3'd1;
    else
      return 3'd2;
  endfunction

  function automatic bus_pkg::strb_t exp_wstrb(input bus_pkg::addr_t a, input bus_pkg::strb_t s);
    bus_pkg::strb_t r;
    r = '0;
    for (int k = 0; k < 4; k++)
      if (s[k] && a[1:0] + k < 4)
        r[4 * a[2] + a[1:0] + k] = 1'b1;
    return r;
  endfunction

  // byte k of the store word lands at byte offset plus k
  function automatic bus_pkg::beat_t merge(input bus_pkg::beat_t b, input bus_pkg::addr_t a,
                                           input bus_pkg::word_t d, input bus_pkg::strb_t s);
    int lane;
    for (int k = 0; k < 4; k++)
    begin
      lane = 4 * a[2] + a[1:0] + k;
      if (s[k] && a[1:0] + k < 4)
        b[8 * lane +: 8] = d[8 * k +: 8];
    end
    return b;
  endfunction

  // axi slave with random ready and valid delays
  always @(posedge clk)
  begin
    if (rst)
    begin
      m_arready_i <= 1'b0;
      m_rvalid_i  <= 1'b0;
      m_awready_i <= 1'b0;
      m_wready_i  <= 1'b0;
      m_bvalid_i  <= 1'b0;
      r_pend = 0;
      aw_got = 0;
      w_got = 0;
      b_pend = 0;
      ar_wait = urand(4);
      aw_wait = urand(4);
      w_wait = urand(4);
    end
    else
    begin
      if (m_arvalid_o && m_arready_i)
      begin
        m_arready_i <= 1'b0;
        r_addr = m_araddr_o;
        last_arsize = m_arsize_o;
        ar_count++;
        r_pend = 1;
        r_wait = urand(4);
        ar_wait = urand(4);
      end
      else if (m_arvalid_o)
      begin
        if (ar_wait == 0)
          m_arready_i <= 1'b1;
        else
          ar_wait--;
      end
      if (m_rvalid_i && m_rready_o)
        m_rvalid_i <= 1'b0;
      else if (r_pend)
      begin
        if (r_wait == 0)
        begin
          m_rvalid_i <= 1'b1;
          m_rdata_i  <= mem_peek(r_addr);
          r_pend = 0;
        end
        else
          r_wait--;
      end
      if (m_awvalid_o && m_awready_i)
      begin
        m_awready_i <= 1'b0;
        w_addr = m_awaddr_o;
        last_awsize = m_awsize_o;
        aw_count++;
        aw_got = 1;
        aw_wait = urand(4);
      end
      else if (m_awvalid_o)
      begin
        if (aw_wait == 0)
          m_awready_i <= 1'b1;
        else
          aw_wait--;
      end
      if (m_wvalid_o && m_wready_i)
      begin
        m_wready_i <= 1'b0;
        w_data = m_wdata_o;
        w_strb = m_wstrb_o;
        last_wstrb = m_wstrb_o;
        w_got = 1;
        w_wait = urand(4);
      end
      else if (m_wvalid_o)
      begin
        if (w_wait == 0)
          m_wready_i <= 1'b1;
        else
          w_wait--;
      end
      // apply byte writes once both channels are in
      if (aw_got && w_got && !b_pend && !m_bvalid_i)
      begin
        wb = mem_peek(w_addr);
        for (int i = 0; i < 8; i++)
          if (w_strb[i])
            wb[8 * i +: 8] = w_data[8 * i +: 8];
        ram[{w_addr[31:3], 3'b000}] = wb;
        aw_got = 0;
        w_got = 0;
        b_pend = 1;
        b_wait = urand(4);
      end
      if (m_bvalid_i && m_bready_o)
        m_bvalid_i <= 1'b0;
      else if (b_pend)
      begin
        if (b_wait == 0)
        begin
          m_bvalid_i <= 1'b1;
          b_pend = 0;
        end
        else
          b_wait--;
      end
    end
  end

  task automatic check_word(input string name, input bus_pkg::word_t got,
                            input bus_pkg::word_t exp);
    if (got !== exp)
    begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_size(input string name, input bus_pkg::size_t got,
                            input bus_pkg::size_t exp);
    if (got !== exp)
    begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_strb(input string name, input bus_pkg::strb_t got,
                            input bus_pkg::strb_t exp);
    if (got !== exp)
    begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic flag_failure(input string msg);
    $display("%s", msg);
    err_count++;
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_count++;
    $display("%s finished with %0d errors", name, err_count - errs_before);
  endtask

  task automatic abort_timeout(input string what);
    $display("timeout waiting for %s", what);
    $display("tests failed");
    $finish;
  endtask

  function automatic logic pulse_of(input int which);
    if (which == 0)
      return ifu_rvalid_o;
    else if (which == 1)
      return lsu_rvalid_o;
    else
      return lsu_wready_o;
  endfunction

  // cycles counted from the edge that drove the request
  task automatic wait_pulse(input int which, output int cycles);
    int n;
    n = 0;
    @(negedge clk);
    while (!pulse_of(which) && n < 200)
    begin
      n++;
      @(negedge clk);
    end
    cycles = n;
    if (!pulse_of(which))
      abort_timeout("a core side completion pulse");
  endtask

  task automatic do_fetch(input bus_pkg::addr_t a, output bus_pkg::word_t d);
    int cyc;
    @(posedge clk);
    ifu_araddr_i  <= a;
    ifu_arvalid_i <= 1'b1;
    wait_pulse(0, cyc);
    d = ifu_rdata_o;
    @(posedge clk);
    ifu_arvalid_i <= 1'b0;
  endtask

  task automatic do_load(input bus_pkg::addr_t a, input bus_pkg::strb_t s,
                         output bus_pkg::word_t d, output int cyc);
    @(posedge clk);
    lsu_araddr_i  <= a;
    lsu_rstrb_i   <= s;
    lsu_arvalid_i <= 1'b1;
    wait_pulse(1, cyc);
    d = lsu_rdata_o;
    @(posedge clk);
    lsu_arvalid_i <= 1'b0;
  endtask

  task automatic do_store(input bus_pkg::addr_t a, input bus_pkg::word_t d,
                          input bus_pkg::strb_t s);
    int cyc;
    @(posedge clk);
    lsu_awaddr_i <= a;
    lsu_wdata_i  <= d;
    lsu_wstrb_i  <= s;
    lsu_wvalid_i <= 1'b1;
    wait_pulse(2, cyc);
    @(posedge clk);
    lsu_wvalid_i <= 1'b0;
  endtask

  task automatic test_fetch();
    int e0;
    bus_pkg::addr_t a;
    bus_pkg::word_t d;
    e0 = err_count;
    for (int i = 0; i < 4; i++)
      ram[32'h8000_0000 + 8 * i] = {$random(seed), $random(seed)};
    for (int j = 0; j < 8; j++)
    begin
      a = 32'h8000_0000 + 4 * j;
      do_fetch(a, d);
      check_word("ifu_rdata_o", d, exp_read(mem_peek(a), a));
      check_size("m_arsize_o", last_arsize, 3'd2);
    end
    report_test("fetch", e0);
  endtask

  task automatic test_loads();
    int e0;
    int cyc;
    bus_pkg::strb_t sizes [3];
    bus_pkg::addr_t a;
    bus_pkg::word_t d;
    e0 = err_count;
    sizes = '{8'h01, 8'h03, 8'h0f};
    ram[32'h8000_0100] = {$random(seed), $random(seed)};
    for (int h = 0; h < 2; h++)
      for (int off = 0; off < 4; off++)
        for (int s = 0; s < 3; s++)
        begin
          a = 32'h8000_0100 + 4 * h + off;
          do_load(a, sizes[s], d, cyc);
          check_word("lsu_rdata_o", d, exp_read(mem_peek(a), a));
          check_size("m_arsize_o", last_arsize, exp_size(sizes[s]));
        end
    report_test("loads", e0);
  endtask

  task automatic store_and_verify(input bus_pkg::addr_t a, input bus_pkg::strb_t s);
    int cyc;
    int aw0;
    bus_pkg::word_t wd;
    bus_pkg::word_t d;
    bus_pkg::beat_t exp_beat;
    bus_pkg::addr_t wa;
    wd = $random(seed);
    wa = {a[31:2], 2'b00};
    exp_beat = merge(mem_peek(a), a, wd, s);
    aw0 = aw_count;
    do_store(a, wd, s);
    if (aw_count != aw0 + 1)
      flag_failure("a store did not make exactly one write address handshake");
    check_strb("m_wstrb_o", last_wstrb, exp_wstrb(a, s));
    check_size("m_awsize_o", last_awsize, exp_size(s));
    do_load(wa, 8'h0f, d, cyc);
    check_word("lsu_rdata_o", d, exp_read(exp_beat, wa));
  endtask

  task automatic test_stores();
    int e0;
    e0 = err_count;
    for (int h = 0; h < 2; h++)
    begin
      for (int off = 0; off < 4; off++)
        store_and_verify(32'h8000_0200 + 4 * h + off, 8'h01);
      store_and_verify(32'h8000_0200 + 4 * h, 8'h03);
      store_and_verify(32'h8000_0202 + 4 * h, 8'h03);
      store_and_verify(32'h8000_0200 + 4 * h, 8'h0f);
    end
    report_test("stores", e0);
  endtask

  // lsu request and fetch raised in the same cycle
  task automatic run_race(input bit store);
    bus_pkg::addr_t fa;
    bus_pkg::addr_t la;
    bus_pkg::word_t exp_f;
    bus_pkg::word_t exp_l;
    int n;
    int lsu_at;
    int ifu_at;
    fa = 32'h8000_0040;
    la = 32'h8000_0084;
    exp_f = exp_read(mem_peek(fa), fa);
    exp_l = exp_read(mem_peek(la), la);
    n = 0;
    lsu_at = 0;
    ifu_at = 0;
    @(posedge clk);
    ifu_araddr_i  <= fa;
    ifu_arvalid_i <= 1'b1;
    if (store)
    begin
      lsu_awaddr_i <= la;
      lsu_wdata_i  <= $random(seed);
      lsu_wstrb_i  <= 8'h0f;
      lsu_wvalid_i <= 1'b1;
    end
    else
    begin
      lsu_araddr_i  <= la;
      lsu_rstrb_i   <= 8'h0f;
      lsu_arvalid_i <= 1'b1;
    end
    while (ifu_at == 0 && n < 200)
    begin
      @(negedge clk);
      n++;
      if (ifu_rvalid_o)
      begin
        ifu_at = n;
        check_word("ifu_rdata_o", ifu_rdata_o, exp_f);
      end
      if (pulse_of(store ? 2 : 1))
      begin
        lsu_at = n;
        if (!store)
          check_word("lsu_rdata_o", lsu_rdata_o, exp_l);
        @(posedge clk);
        lsu_arvalid_i <= 1'b0;
        lsu_wvalid_i  <= 1'b0;
      end
    end
    if (ifu_at == 0)
      abort_timeout("the fetch in the priority test");
    else
    begin
      @(posedge clk);
      ifu_arvalid_i <= 1'b0;
      if (lsu_at == 0 || lsu_at > ifu_at)
        flag_failure("lsu request did not complete before the fetch");
    end
  endtask

  task automatic test_priority();
    int e0;
    e0 = err_count;
    run_race(1'b0);
    run_race(1'b1);
    report_test("priority", e0);
  endtask

  task automatic test_timer();
    int e0;
    int ar0;
    int c0;
    int c1;
    int c2;
    bus_pkg::word_t t0;
    bus_pkg::word_t t1;
    bus_pkg::word_t th;
    e0 = err_count;
    ar0 = ar_count;
    do_load(`BUS_RTC_ADDR, 8'h0f, t0, c0);
    repeat (10) @(posedge clk);
    do_load(`BUS_RTC_ADDR, 8'h0f, t1, c1);
    do_load(`BUS_RTC_ADDR_UP, 8'h0f, th, c2);
    if (t1 <= t0 || t1 - t0 < 10)
      flag_failure($sformatf("timer advanced from %0d to %0d, expected 10 or more", t0, t1));
    check_word("lsu_rdata_o", th, 32'h0);
    if (ar_count != ar0)
      flag_failure("a timer read reached the axi read address channel");
    if (c0 != 3 || c1 != 3 || c2 != 3)
      flag_failure($sformatf("timer read latency was %0d %0d %0d cycles, not 3", c0, c1, c2));
    report_test("timer", e0);
  endtask

  task automatic test_random();
    int e0;
    int cyc;
    int kind;
    bus_pkg::strb_t sizes [3];
    bus_pkg::strb_t s;
    bus_pkg::addr_t a;
    bus_pkg::word_t d;
    e0 = err_count;
    sizes = '{8'h01, 8'h03, 8'h0f};
    for (int i = 0; i < 40; i++)
    begin
      kind = urand(3);
      s = sizes[urand(3)];
      a = 32'h8000_0400 + 4 * urand(16);
      if (kind == 0)
      begin
        a = a + urand(4);
        do_load(a, s, d, cyc);
        check_word("lsu_rdata_o", d, exp_read(mem_peek(a), a));
      end
      else if (kind == 1)
      begin
        // keep the store inside its word
        if (s == 8'h01)
          a = a + urand(4);
        else if (s == 8'h03)
          a = a + 2 * urand(2);
        store_and_verify(a, s);
      end
      else
      begin
        do_fetch(a, d);
        check_word("ifu_rdata_o", d, exp_read(mem_peek(a), a));
      end
    end
    report_test("back-pressure", e0);
  endtask

  initial
  begin
    rst           <= 1'b1;
    ifu_araddr_i  <= '0;
    ifu_arvalid_i <= 1'b0;
    lsu_araddr_i  <= '0;
    lsu_arvalid_i <= 1'b0;
    lsu_rstrb_i   <= '0;
    lsu_awaddr_i  <= '0;
    lsu_wdata_i   <= '0;
    lsu_wstrb_i   <= '0;
    lsu_wvalid_i  <= 1'b0;
    m_arready_i   <= 1'b0;
    m_rvalid_i    <= 1'b0;
    m_awready_i   <= 1'b0;
    m_wready_i    <= 1'b0;
    m_bvalid_i    <= 1'b0;
    m_rdata_i     <= '0;
    m_rresp_i     <= `BUS_RESP_OKAY;
    m_bresp_i     <= `BUS_RESP_OKAY;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    test_fetch();
    test_loads();
    test_stores();
    test_priority();
    test_timer();
    test_random();
    $display("%0d tests run, %0d errors", test_count, err_count);
    if (err_count == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

/* cpu_bus_top.sv */
`timescale 1ns/100ps

module cpu_bus_top (
  input  logic            clk,
  input  logic            rst,
  input  bus_pkg::addr_t  ifu_araddr_i,
  input  logic            ifu_arvalid_i,
  output bus_pkg::word_t  ifu_rdata_o,
  output logic            ifu_rvalid_o,
  input  bus_pkg::addr_t  lsu_araddr_i,
  input  logic            lsu_arvalid_i,
  input  bus_pkg::strb_t  lsu_rstrb_i,
  output bus_pkg::word_t  lsu_rdata_o,
  output logic            lsu_rvalid_o,
  input  bus_pkg::addr_t  lsu_awaddr_i,
  input  bus_pkg::word_t  lsu_wdata_i,
  input  bus_pkg::strb_t  lsu_wstrb_i,
  input  logic            lsu_wvalid_i,
  output logic            lsu_wready_o,
  output bus_pkg::addr_t  m_araddr_o,
  output bus_pkg::size_t  m_arsize_o,
  output logic            m_arvalid_o,
  input  logic            m_arready_i,
  input  bus_pkg::beat_t  m_rdata_i,
  input  bus_pkg::resp_t  m_rresp_i,
  input  logic            m_rvalid_i,
  output logic            m_rready_o,
  output bus_pkg::addr_t  m_awaddr_o,
  output bus_pkg::size_t  m_awsize_o,
  output logic            m_awvalid_o,
  input  logic            m_awready_i,
  output bus_pkg::beat_t  m_wdata_o,
  output bus_pkg::strb_t  m_wstrb_o,
  output logic            m_wvalid_o,
  input  logic            m_wready_i,
  input  bus_pkg::resp_t  m_bresp_i,
  input  logic            m_bvalid_i,
  output logic            m_bready_o
);

  mem_req_if  mem_req ();
  clint_rd_if clint_rd ();

  bus_arbiter bus_arbiter_i (
    .clk           (clk),
    .rst           (rst),
    .ifu_araddr_i  (ifu_araddr_i),
    .ifu_arvalid_i (ifu_arvalid_i),
    .lsu_araddr_i  (lsu_araddr_i),
    .lsu_arvalid_i (lsu_arvalid_i),
    .lsu_rstrb_i   (lsu_rstrb_i),
    .lsu_awaddr_i  (lsu_awaddr_i),
    .lsu_wdata_i   (lsu_wdata_i),
    .lsu_wstrb_i   (lsu_wstrb_i),
    .lsu_wvalid_i  (lsu_wvalid_i),
    .ifu_rdata_o   (ifu_rdata_o),
    .lsu_rdata_o   (lsu_rdata_o),
    .ifu_rvalid_o  (ifu_rvalid_o),
    .lsu_rvalid_o  (lsu_rvalid_o),
    .lsu_wready_o  (lsu_wready_o),
    .mem           (mem_req.arb),
    .clint         (clint_rd.arb)
  );

  axi_master_port axi_master_port_i (
    .clk         (clk),
    .rst         (rst),
    .mem         (mem_req.port),
    .m_araddr_o  (m_araddr_o),
    .m_arsize_o  (m_arsize_o),
    .m_arvalid_o (m_arvalid_o),
    .m_arready_i (m_arready_i),
    .m_rdata_i   (m_rdata_i),
    .m_rresp_i   (m_rresp_i),
    .m_rvalid_i  (m_rvalid_i),
    .m_rready_o  (m_rready_o),
    .m_awaddr_o  (m_awaddr_o),
    .m_awsize_o  (m_awsize_o),
    .m_awvalid_o (m_awvalid_o),
    .m_awready_i (m_awready_i),
    .m_wdata_o   (m_wdata_o),
    .m_wstrb_o   (m_wstrb_o),
    .m_wvalid_o  (m_wvalid_o),
    .m_wready_i  (m_wready_i),
    .m_bresp_i   (m_bresp_i),
    .m_bvalid_i  (m_bvalid_i),
    .m_bready_o  (m_bready_o)
  );

  clint clint_i (
    .clk (clk),
    .rst (rst),
    .rd  (clint_rd.clint)
  );

endmodule

/* mem_req_if.sv */
`timescale 1ns/100ps

interface mem_req_if;

  // request side, held until done
  logic              rd_valid;
  logic              wr_valid;
  bus_pkg::addr_t    addr;
  bus_pkg::strb_t    strb;
  bus_pkg::word_t    wdata;

  // completion side
  logic              done;
  bus_pkg::word_t    rdata;

  modport arb (
    output rd_valid,
    output wr_valid,
    output addr,
    output strb,
    output wdata,
    input  done,
    input  rdata
  );

  modport port (
    input  rd_valid,
    input  wr_valid,
    input  addr,
    input  strb,
    input  wdata,
    output done,
    output rdata
  );

endinterface
